//--- design/plru_geom_pkg.sv
//##################################################
// Cache geometry for the pseudo-LRU unit
// Way, set and tree-bit counts, their vector types
// and the node numbering of the decision tree
//##################################################

package plru_geom_pkg;

    localparam int unsigned NumWays    = 8;
    localparam int unsigned TreeBits   = NumWays - 1;
    localparam int unsigned TreeLevels = $clog2(NumWays);
    localparam int unsigned NumSets    = 64;
    localparam int unsigned IndexWidth = $clog2(NumSets);

    // One bit per way, highest way in the MSB
    typedef logic [NumWays-1:0]    way_mask_t;
    typedef logic [TreeBits-1:0]   tree_bits_t;
    typedef logic [IndexWidth-1:0] set_index_t;

    // Bit position of node (level, group) in the pre-order layout
    // Group 0 is the subtree holding the highest ways of its level
    function automatic int unsigned node_idx(input int unsigned level,
                                             input int unsigned group);
        int unsigned idx;
        idx = 0;
        for (int unsigned k = 0; k < level; k++) begin
            // Lower half sits after the whole upper subtree
            if (((group >> (level - 1 - k)) & 1) != 0) begin
                idx += NumWays >> (k + 1);
            end else begin
                idx += 1;
            end
        end
        return idx;
    endfunction

endpackage

//--- design/plru_req_pkg.sv
//##################################################
// Request and result formats of the PLRU unit
// Operation codes, request and result structs,
// controller states
//##################################################

package plru_req_pkg;

    // Kind of request
    typedef enum logic {
        OP_HIT   = 1'b0,
        OP_EVICT = 1'b1
    } plru_op_e;

    // One request, hit or evict
    typedef struct packed {
        plru_op_e                 op;
        plru_geom_pkg::set_index_t index;
        // One-hot, meaningful for a hit
        plru_geom_pkg::way_mask_t hit_way;
        // Per-way state, meaningful for an evict
        plru_geom_pkg::way_mask_t valid_ways;
        plru_geom_pkg::way_mask_t lock_ways;
        plru_geom_pkg::way_mask_t dirty_ways;
    } plru_req_t;

    // Answer to an evict
    typedef struct packed {
        plru_geom_pkg::way_mask_t victim_way;
        logic                     victim_dirty;
    } plru_result_t;

    typedef enum logic {
        IDLE,
        UPDATE
    } ctrl_state_e;

endpackage

//--- design/plru_tree_store.sv
//##################################################
// Tree-bit storage, one entry per cache set
// Registered read port and one write port
//##################################################

`timescale 1ns/1ps

module plru_tree_store (
    input  logic                      clk_i,
    input  logic                      arst_n_i,
    input  logic                      rd_en_i,
    input  plru_geom_pkg::set_index_t rd_index_i,
    output plru_geom_pkg::tree_bits_t rd_bits_o,
    input  logic                      wr_en_i,
    input  plru_geom_pkg::set_index_t wr_index_i,
    input  plru_geom_pkg::tree_bits_t wr_bits_i
);

    plru_geom_pkg::tree_bits_t mem [plru_geom_pkg::NumSets];

    // Write port, all sets start with every node at zero
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < plru_geom_pkg::NumSets; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_en_i) begin
            mem[wr_index_i] <= wr_bits_i;
        end
    end

    // Read data appears one cycle after rd_en_i
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rd_bits_o <= '0;
        end else if (rd_en_i) begin
            rd_bits_o <= mem[rd_index_i];
        end
    end

endmodule

//--- design/plru_hit_update.sv
//##################################################
// Hit path of the PLRU tree
// Points every node on the path to the hit way
// towards that way
//##################################################

`timescale 1ns/1ps

module plru_hit_update (
    input  plru_geom_pkg::tree_bits_t cur_bits_i,
    input  plru_geom_pkg::way_mask_t  hit_way_i,
    output plru_geom_pkg::tree_bits_t new_bits_o
);

    localparam int unsigned NumWays = plru_geom_pkg::NumWays;

    for (genvar l = 0; l < plru_geom_pkg::TreeLevels; l++) begin : g_level
        for (genvar g = 0; g < (1 << l); g++) begin : g_node
            // Way range covered by this node
            localparam int unsigned W   = NumWays >> l;
            localparam int unsigned Hi  = NumWays - 1 - g * W;
            localparam int unsigned Lo  = Hi - W + 1;
            localparam int unsigned Mid = Lo + W / 2;
            localparam int unsigned Idx = plru_geom_pkg::node_idx(l, g);

            logic in_subtree;
            logic in_upper;

            assign in_subtree = |hit_way_i[Hi:Lo];
            assign in_upper   = |hit_way_i[Hi:Mid];

            // 0 marks the upper half as most recent, 1 the lower half
            assign new_bits_o[Idx] = in_subtree ? ~in_upper : cur_bits_i[Idx];
        end
    end

endmodule

//--- design/plru_victim_select.sv
//##################################################
// Victim path of the PLRU tree
// Walks from the root under valid and lock masks,
// returns a one-hot victim and the new tree bits
//##################################################

`timescale 1ns/1ps

module plru_victim_select (
    input  plru_geom_pkg::tree_bits_t cur_bits_i,
    input  plru_geom_pkg::way_mask_t  valid_ways_i,
    input  plru_geom_pkg::way_mask_t  lock_ways_i,
    output plru_geom_pkg::way_mask_t  victim_way_o,
    output plru_geom_pkg::tree_bits_t new_bits_o
);

    localparam int unsigned NumWays = plru_geom_pkg::NumWays;

    plru_geom_pkg::way_mask_t  occupied;
    // Decision of every node, as if it lay on the path
    plru_geom_pkg::tree_bits_t node_dec;
    // Node reached by the walk
    plru_geom_pkg::tree_bits_t on_path;

    assign occupied = valid_ways_i | lock_ways_i;

    for (genvar l = 0; l < plru_geom_pkg::TreeLevels; l++) begin : g_level
        for (genvar g = 0; g < (1 << l); g++) begin : g_node
            localparam int unsigned W   = NumWays >> l;
            localparam int unsigned Hi  = NumWays - 1 - g * W;
            localparam int unsigned Lo  = Hi - W + 1;
            localparam int unsigned Mid = Lo + W / 2;
            localparam int unsigned Idx = plru_geom_pkg::node_idx(l, g);

            // The root is always walked, others follow the parent decision
            if (l == 0) begin : g_root
                assign on_path[Idx] = 1'b1;
            end else begin : g_child
                localparam int unsigned PIdx = plru_geom_pkg::node_idx(l - 1, g >> 1);
                assign on_path[Idx] = on_path[PIdx] & (node_dec[PIdx] == (g % 2));
            end

            if (W == 2) begin : g_leaf
                // Only locks count here, a single locked way forces its sibling
                always_comb begin
                    if (lock_ways_i[Hi] && !lock_ways_i[Lo]) begin
                        node_dec[Idx] = 1'b1;
                    end else if (lock_ways_i[Lo] && !lock_ways_i[Hi]) begin
                        node_dec[Idx] = 1'b0;
                    end else begin
                        node_dec[Idx] = ~cur_bits_i[Idx];
                    end
                end

                assign victim_way_o[Hi] = on_path[Idx] & ~node_dec[Idx];
                assign victim_way_o[Lo] = on_path[Idx] & node_dec[Idx];
            end else begin : g_inner
                logic all_occ;
                logic upper_full;
                logic lower_full;

                assign all_occ = &occupied[Hi:Lo];

                // With no free way left, only fully locked halves are avoided
                assign upper_full = all_occ ? &lock_ways_i[Hi:Mid] : &occupied[Hi:Mid];
                assign lower_full = all_occ ? &lock_ways_i[Mid-1:Lo] : &occupied[Mid-1:Lo];

                always_comb begin
                    if (upper_full) begin
                        node_dec[Idx] = 1'b1;
                    end else if (lower_full) begin
                        node_dec[Idx] = 1'b0;
                    end else begin
                        node_dec[Idx] = ~cur_bits_i[Idx];
                    end
                end
            end

            assign new_bits_o[Idx] = on_path[Idx] ? node_dec[Idx] : cur_bits_i[Idx];
        end
    end

endmodule

//--- design/plru_update_ctrl.sv
//##################################################
// PLRU update controller
// Accepts one request, reads the set, writes back
// the hit or victim bits and drives result pulses
//##################################################

`timescale 1ns/1ps

module plru_update_ctrl (
    input  logic                       clk_i,
    input  logic                       arst_n_i,
    input  logic                       req_valid_i,
    input  plru_req_pkg::plru_req_t    req_i,
    output logic                       busy_o,
    output logic                       rd_en_o,
    output plru_geom_pkg::set_index_t  rd_index_o,
    input  plru_geom_pkg::tree_bits_t  rd_bits_i,
    output plru_geom_pkg::way_mask_t   hit_way_o,
    output plru_geom_pkg::way_mask_t   valid_ways_o,
    output plru_geom_pkg::way_mask_t   lock_ways_o,
    input  plru_geom_pkg::tree_bits_t  hit_bits_i,
    input  plru_geom_pkg::tree_bits_t  victim_bits_i,
    input  plru_geom_pkg::way_mask_t   victim_way_i,
    output logic                       wr_en_o,
    output plru_geom_pkg::set_index_t  wr_index_o,
    output plru_geom_pkg::tree_bits_t  wr_bits_o,
    output logic                       hit_done_o,
    output logic                       victim_valid_o,
    output plru_req_pkg::plru_result_t victim_o
);

    plru_req_pkg::ctrl_state_e state_q;
    plru_req_pkg::ctrl_state_e state_d;
    plru_req_pkg::plru_req_t   req_q;

    logic accept;
    logic in_update;
    logic is_evict;

    assign in_update = (state_q == plru_req_pkg::UPDATE);
    assign accept    = req_valid_i && (state_q == plru_req_pkg::IDLE);
    assign is_evict  = (req_q.op == plru_req_pkg::OP_EVICT);
    assign busy_o    = in_update;

    // Tree read is issued in the same cycle the request is taken
    assign rd_en_o    = accept;
    assign rd_index_o = req_i.index;

    // Both paths see the latched request
    assign hit_way_o    = req_q.hit_way;
    assign valid_ways_o = req_q.valid_ways;
    assign lock_ways_o  = req_q.lock_ways;

    assign wr_bits_o  = is_evict ? victim_bits_i : hit_bits_i;
    assign wr_index_o = req_q.index;
    // No write needed when the path bits are already in place
    assign wr_en_o    = in_update && (wr_bits_o != rd_bits_i);

    always_comb begin
        state_d = state_q;
        case (state_q)
            plru_req_pkg::IDLE: begin
                if (accept) begin
                    state_d = plru_req_pkg::UPDATE;
                end
            end
            plru_req_pkg::UPDATE: begin
                state_d = plru_req_pkg::IDLE;
            end
            default: begin
                state_d = plru_req_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= plru_req_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            req_q <= req_i;
        end
    end

    // Result pulses, one cycle after acceptance
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            hit_done_o     <= 1'b0;
            victim_valid_o <= 1'b0;
            victim_o       <= '0;
        end else begin
            hit_done_o     <= in_update && !is_evict;
            victim_valid_o <= in_update && is_evict;
            if (in_update && is_evict) begin
                victim_o.victim_way   <= victim_way_i;
                victim_o.victim_dirty <= |(victim_way_i & req_q.dirty_ways);
            end
        end
    end

endmodule

//--- design/plru_cache_top.sv
//##################################################
// PLRU replacement unit top level
// Tree storage, hit path, victim path, controller
//##################################################

`timescale 1ns/1ps

module plru_cache_top (
    input  logic                       clk_i,
    input  logic                       arst_n_i,
    input  logic                       req_valid_i,
    input  plru_req_pkg::plru_req_t    req_i,
    output logic                       busy_o,
    output logic                       hit_done_o,
    output logic                       victim_valid_o,
    output plru_req_pkg::plru_result_t victim_o
);

    logic                      rd_en;
    plru_geom_pkg::set_index_t rd_index;
    plru_geom_pkg::tree_bits_t rd_bits;
    logic                      wr_en;
    plru_geom_pkg::set_index_t wr_index;
    plru_geom_pkg::tree_bits_t wr_bits;

    plru_geom_pkg::way_mask_t  hit_way;
    plru_geom_pkg::way_mask_t  valid_ways;
    plru_geom_pkg::way_mask_t  lock_ways;
    plru_geom_pkg::tree_bits_t hit_bits;
    plru_geom_pkg::tree_bits_t victim_bits;
    plru_geom_pkg::way_mask_t  victim_way;

    plru_tree_store u_store (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .rd_en_i    (rd_en),
        .rd_index_i (rd_index),
        .rd_bits_o  (rd_bits),
        .wr_en_i    (wr_en),
        .wr_index_i (wr_index),
        .wr_bits_i  (wr_bits)
    );

    // Both paths work on the same read data
    plru_hit_update u_hit (
        .cur_bits_i (rd_bits),
        .hit_way_i  (hit_way),
        .new_bits_o (hit_bits)
    );

    plru_victim_select u_victim (
        .cur_bits_i   (rd_bits),
        .valid_ways_i (valid_ways),
        .lock_ways_i  (lock_ways),
        .victim_way_o (victim_way),
        .new_bits_o   (victim_bits)
    );

    plru_update_ctrl u_ctrl (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .req_valid_i    (req_valid_i),
        .req_i          (req_i),
        .busy_o         (busy_o),
        .rd_en_o        (rd_en),
        .rd_index_o     (rd_index),
        .rd_bits_i      (rd_bits),
        .hit_way_o      (hit_way),
        .valid_ways_o   (valid_ways),
        .lock_ways_o    (lock_ways),
        .hit_bits_i     (hit_bits),
        .victim_bits_i  (victim_bits),
        .victim_way_i   (victim_way),
        .wr_en_o        (wr_en),
        .wr_index_o     (wr_index),
        .wr_bits_o      (wr_bits),
        .hit_done_o     (hit_done_o),
        .victim_valid_o (victim_valid_o),
        .victim_o       (victim_o)
    );

endmodule

//--- tb/plru_checker.sv
//##################################################
// Protocol and victim legality assertions,
// bound into the PLRU top level
//##################################################

`timescale 1ns/1ps

module plru_checker (
    input logic                       clk_i,
    input logic                       arst_n_i,
    input logic                       req_valid_i,
    input plru_req_pkg::plru_req_t    req_i,
    input logic                       busy_i,
    input logic                       hit_done_i,
    input logic                       victim_valid_i,
    input plru_req_pkg::plru_result_t victim_i
);

    logic                     accept;
    plru_geom_pkg::way_mask_t lock_q;
    int unsigned              fail_count = 0;

    assign accept = req_valid_i && !busy_i;

    // Lock mask of the request in flight
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            lock_q <= '0;
        end else if (accept) begin
            lock_q <= req_i.lock_ways;
        end
    end

    a_onehot: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        victim_valid_i |-> $onehot(victim_i.victim_way))
    else begin
        $error("Victim way is not one-hot");
        fail_count++;
    end

    a_single_pulse: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (hit_done_i || victim_valid_i) |=> !(hit_done_i || victim_valid_i))
    else begin
        $error("Result pulse longer than one cycle");
        fail_count++;
    end

    // Busy for one cycle, then exactly one kind of result pulse
    a_latency: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        accept |=> busy_i ##1 (hit_done_i ^ victim_valid_i))
    else begin
        $error("Result pulse not one cycle after acceptance");
        fail_count++;
    end

    a_busy_drop: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (req_valid_i && busy_i) |=> !busy_i)
    else begin
        $error("Request taken while busy");
        fail_count++;
    end

    a_lock: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (victim_valid_i && !(&lock_q)) |-> ((victim_i.victim_way & lock_q) == '0))
    else begin
        $error("Locked way chosen while an unlocked way exists");
        fail_count++;
    end

endmodule

bind plru_cache_top plru_checker u_checker (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .req_valid_i    (req_valid_i),
    .req_i          (req_i),
    .busy_i         (busy_o),
    .hit_done_i     (hit_done_o),
    .victim_valid_i (victim_valid_o),
    .victim_i       (victim_o)
);

//--- tb/plru_tb.sv
//##################################################
// Testbench for the PLRU replacement unit
// Clock, reset, reference tree model, directed and
// random requests, error counts and closing message
//##################################################

`timescale 1ns/1ps

module plru_tb;

    // Reset, round robin, hit then evict pairs, locks, random mix, busy offers
    localparam int NumReqs   = 1 + 8 + 32 + 8 + 200 + 4;
    localparam int MaxCycles = NumReqs * 3 + 100;

    logic                       clk = 1'b0;
    logic                       arst_n;
    logic                       req_valid;
    plru_req_pkg::plru_req_t    req;
    logic                       busy;
    logic                       hit_done;
    logic                       victim_valid;
    plru_req_pkg::plru_result_t victim;

    plru_geom_pkg::tree_bits_t model_tree [plru_geom_pkg::NumSets] = '{default: '0};
    integer seed   = 32'h685a_db3e;
    int     errors = 0;
    int     cycles = 0;

    plru_cache_top UUT (
        .clk_i          (clk),
        .arst_n_i       (arst_n),
        .req_valid_i    (req_valid),
        .req_i          (req),
        .busy_o         (busy),
        .hit_done_o     (hit_done),
        .victim_valid_o (victim_valid),
        .victim_o       (victim)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > MaxCycles) begin
            $display("Timeout, run still going after %0d cycles", cycles);
            $display("Checks failed");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected)
        else begin
            $display("CHECK FAILED %s expected %h got %h", name, expected, actual);
            errors++;
        end
    endtask

    function automatic bit all_set(input plru_geom_pkg::way_mask_t m, input int hi,
                                   input int lo);
        bit r;
        r = 1'b1;
        for (int i = lo; i <= hi; i++) begin
            r &= m[i];
        end
        return r;
    endfunction

    // Reference walk from the root returning the new tree bits and the way reached
    function automatic plru_geom_pkg::tree_bits_t model_walk(
        input plru_geom_pkg::tree_bits_t bits, input plru_req_pkg::plru_req_t r,
        output int way);
        plru_geom_pkg::tree_bits_t nb;
        plru_geom_pkg::way_mask_t  occ;
        int   p;
        int   hi;
        int   w;
        int   hw;
        logic dec;
        nb  = bits;
        occ = r.valid_ways | r.lock_ways;
        p   = 0;
        hi  = plru_geom_pkg::NumWays - 1;
        hw  = 0;
        for (int i = 0; i < plru_geom_pkg::NumWays; i++) begin
            if (r.hit_way[i]) begin
                hw = i;
            end
        end
        for (w = plru_geom_pkg::NumWays; w >= 2; w = w / 2) begin
            if (r.op == plru_req_pkg::OP_HIT) begin
                dec = (hw <= hi - w / 2);
            end else if (w == 2) begin
                // At the leaf a single lock sends the victim to the sibling
                dec = (r.lock_ways[hi] != r.lock_ways[hi-1]) ? r.lock_ways[hi] : ~nb[p];
            end else if (all_set(occ, hi, hi - w + 1)) begin
                dec = all_set(r.lock_ways, hi, hi - w / 2 + 1) ? 1'b1
                    : all_set(r.lock_ways, hi - w / 2, hi - w + 1) ? 1'b0 : ~nb[p];
            end else begin
                dec = all_set(occ, hi, hi - w / 2 + 1) ? 1'b1
                    : all_set(occ, hi - w / 2, hi - w + 1) ? 1'b0 : ~nb[p];
            end
            nb[p] = dec;
            // Lower half subtree starts after the upper one
            if (dec) begin
                p  = p + w / 2;
                hi = hi - w / 2;
            end else begin
                p = p + 1;
            end
        end
        way = hi;
        return nb;
    endfunction

    // One request with result and tree checks and an optional second offer while busy
    task automatic run_req(input plru_req_pkg::plru_req_t r, input bit intrude);
        plru_geom_pkg::tree_bits_t exp_bits;
        plru_req_pkg::plru_req_t   other;
        int way;
        int waited;
        exp_bits          = model_walk(model_tree[r.index], r, way);
        other             = r;
        other.op          = plru_req_pkg::OP_EVICT;
        other.index       = r.index + 6'd1;
        other.valid_ways  = '0;
        other.lock_ways   = '0;
        while (busy) begin
            @(negedge clk);
        end
        @(posedge clk);
        req_valid <= 1'b1;
        req       <= r;
        @(posedge clk);
        if (intrude) begin
            req <= other;
        end else begin
            req_valid <= 1'b0;
        end
        @(negedge clk);
        check_value("busy_o", 1, busy);
        @(posedge clk);
        req_valid <= 1'b0;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!hit_done && !victim_valid && waited < 4);
        assert (waited == 1)
        else begin
            $display("Result pulse did not come one cycle after the request was taken");
            errors++;
        end
        check_value("busy_o", 0, busy);
        check_value("hit_done_o", r.op == plru_req_pkg::OP_HIT, hit_done);
        check_value("victim_valid_o", r.op == plru_req_pkg::OP_EVICT, victim_valid);
        if (r.op == plru_req_pkg::OP_EVICT) begin
            check_value("victim_way", 1 << way, victim.victim_way);
            check_value("victim_dirty", r.dirty_ways[way], victim.victim_dirty);
        end
        model_tree[r.index] = exp_bits;
        check_value("tree_bits", exp_bits, UUT.u_store.mem[r.index]);
        if (intrude) begin
            repeat (3) begin
                @(negedge clk);
                check_value("hit_done_o|victim_valid_o", 0, hit_done | victim_valid);
            end
            check_value("tree_bits", model_tree[other.index], UUT.u_store.mem[other.index]);
        end
    endtask

    initial begin
        plru_req_pkg::plru_req_t  r;
        logic [31:0]              rnd;
        plru_geom_pkg::way_mask_t seen;
        arst_n    = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check_value("busy_o/hit_done_o/victim_valid_o/victim_o", 0,
                    {busy, hit_done, victim_valid, victim});

        // On a fresh set every node flips to the lower half
        r = '{plru_req_pkg::OP_EVICT, 6'd5, 8'h00, 8'h00, 8'h00, 8'hfe};
        run_req(r, 1'b0);
        check_value("victim_way", 8'h01, victim.victim_way);

        seen    = '0;
        r.index = 6'd9;
        repeat (8) begin
            run_req(r, 1'b0);
            seen |= victim.victim_way;
        end
        check_value("ways visited", 8'hff, seen);

        // A just-hit way is never the next victim
        repeat (16) begin
            rnd = $random(seed);
            r   = '{plru_req_pkg::OP_HIT, rnd[5:0], 8'h01 << rnd[8:6], 8'h00, 8'h00, rnd[31:24]};
            run_req(r, 1'b0);
            r.op = plru_req_pkg::OP_EVICT;
            run_req(r, 1'b0);
            check_value("victim_way & hit_way", 0, victim.victim_way & r.hit_way);
        end

        for (int i = 0; i < 8; i++) begin
            rnd = $random(seed);
            r   = '{plru_req_pkg::OP_EVICT, rnd[5:0], 8'h00, 8'hff,
                    (i % 2) ? 8'h0f : 8'hf0, rnd[15:8]};
            run_req(r, 1'b0);
            check_value("victim_way & lock_ways", 0, victim.victim_way & r.lock_ways);
        end

        // Mixed traffic over eight sets with random masks
        repeat (200) begin
            rnd          = $random(seed);
            r.op         = plru_req_pkg::plru_op_e'(rnd[0]);
            r.index      = {3'b000, rnd[3:1]};
            r.hit_way    = 8'h01 << rnd[6:4];
            r.valid_ways = rnd[15:8];
            r.lock_ways  = rnd[23:16] & rnd[31:24];
            r.dirty_ways = rnd[31:24];
            run_req(r, 1'b0);
        end

        repeat (4) begin
            rnd     = $random(seed);
            r.index = rnd[5:0];
            run_req(r, 1'b1);
        end

        @(negedge clk);
        $display("Errors: %0d in testbench checks, %0d in assertions", errors,
                 UUT.u_checker.fail_count);
        if (errors == 0 && UUT.u_checker.fail_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- tb.f
design/plru_geom_pkg.sv
design/plru_req_pkg.sv
design/plru_tree_store.sv
design/plru_hit_update.sv
design/plru_victim_select.sv
design/plru_update_ctrl.sv
design/plru_cache_top.sv
tb/plru_checker.sv
tb/plru_tb.sv

//--- Bender.yml
package:
  name: plru_cache

sources:
  - design/plru_geom_pkg.sv
  - design/plru_req_pkg.sv
  - design/plru_tree_store.sv
  - design/plru_hit_update.sv
  - design/plru_victim_select.sv
  - design/plru_update_ctrl.sv
  - design/plru_cache_top.sv
  - target: test
    files:
      - tb/plru_checker.sv
      - tb/plru_tb.sv
